// ==== core_isa_pkg.sv ====
`default_nettype none

package core_isa_pkg;

  localparam int XLEN     = 32;
  localparam int REG_BITS = 5;

  typedef logic [XLEN-1:0]     xlen_t;
  typedef logic [REG_BITS-1:0] reg_addr_t;

  // {funct7[5], funct3} of the RV32I register/immediate ops
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sub  = 4'b1000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_sra  = 4'b1101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111
  } alu_op_e;

  // M extension funct3
  typedef enum logic [2:0] {
    md_mul    = 3'd0,
    md_mulh   = 3'd1,
    md_mulhsu = 3'd2,
    md_mulhu  = 3'd3,
    md_div    = 3'd4,
    md_divu   = 3'd5,
    md_rem    = 3'd6,
    md_remu   = 3'd7
  } muldiv_op_e;

  // one operation word, read per execute path
  typedef union packed {
    alu_op_e alu;
    struct packed {
      logic       spare;
      muldiv_op_e op;
    } md;
  } exec_op_u;

endpackage

`default_nettype wire

// ==== core_pipe_pkg.sv ====
`default_nettype none

package core_pipe_pkg;

  // execute path of an issued instruction
  typedef enum logic [1:0] {
    path_alu    = 2'd0,
    path_muldiv = 2'd1
  } exec_path_e;

  // one quotient bit per step
  localparam int DIV_STEPS = core_isa_pkg::XLEN;

  // step counter width
  localparam int DIV_CNT_BITS = $clog2(DIV_STEPS);

endpackage

`default_nettype wire

// ==== opfetch_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module opfetch_stage
  import core_isa_pkg::*, core_pipe_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,

  input  logic       issue_valid_i,
  input  exec_op_u   op_i,
  input  exec_path_e path_i,
  input  reg_addr_t  rd_addr_i,
  input  reg_addr_t  rs1_addr_i,
  input  reg_addr_t  rs2_addr_i,
  input  logic       imm_valid_i,
  input  xlen_t      imm_i,
  output logic       issue_ready_o,

  output reg_addr_t  rf_rs1_addr_o,
  output reg_addr_t  rf_rs2_addr_o,
  input  xlen_t      rf_rs1_i,
  input  xlen_t      rf_rs2_i,

  input  logic       ex_accept_i,
  output logic       of_valid_o,
  output exec_op_u   of_op_o,
  output exec_path_e of_path_o,
  output reg_addr_t  of_rd_o,
  output reg_addr_t  of_rs1_addr_o,
  output reg_addr_t  of_rs2_addr_o,
  output xlen_t      of_rs1_o,
  output xlen_t      of_rs2_o,
  output logic       of_imm_valid_o,
  output xlen_t      of_imm_o
);

  logic capture;

  // free slot, or the held entry leaves on this edge
  assign issue_ready_o = ~of_valid_o | ex_accept_i;
  assign capture       = issue_valid_i & issue_ready_o;

  // register file is read straight from the issue inputs
  assign rf_rs1_addr_o = rs1_addr_i;
  assign rf_rs2_addr_o = rs2_addr_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      of_valid_o <= 1'b0;
    end else if (capture) begin
      of_valid_o <= 1'b1;
    end else if (ex_accept_i) begin
      of_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      of_op_o        <= op_i;
      of_path_o      <= path_i;
      of_rd_o        <= rd_addr_i;
      of_rs1_addr_o  <= rs1_addr_i;
      of_rs2_addr_o  <= rs2_addr_i;
      of_rs1_o       <= rf_rs1_i;
      of_rs2_o       <= rf_rs2_i;
      of_imm_valid_o <= imm_valid_i;
      of_imm_o       <= imm_i;
    end
  end

  // a stalled entry must survive untouched until execute takes it
  a_hold_while_stalled: assert property (@(posedge clk_i) disable iff (reset_i)
    (of_valid_o && !ex_accept_i) |=>
      (of_valid_o && $stable({of_op_o, of_rd_o, of_rs1_o, of_rs2_o, of_imm_o})));

endmodule

`default_nettype wire

// ==== alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu
  import core_isa_pkg::*;
(
  input  alu_op_e op_i,
  input  xlen_t   a_i,
  input  xlen_t   b_i,
  output xlen_t   result_o
);

  logic [$clog2(XLEN)-1:0] shamt;

  // shift amount is the low bits of the second operand only
  assign shamt = b_i[$clog2(XLEN)-1:0];

  always_comb begin
    case (op_i)
      alu_add:  result_o = a_i + b_i;
      alu_sub:  result_o = a_i - b_i;
      alu_sll:  result_o = a_i << shamt;
      alu_slt:  result_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      alu_sltu: result_o = {{(XLEN-1){1'b0}}, a_i < b_i};
      alu_xor:  result_o = a_i ^ b_i;
      alu_srl:  result_o = a_i >> shamt;
      alu_sra:  result_o = xlen_t'($signed(a_i) >>> shamt);
      alu_or:   result_o = a_i | b_i;
      alu_and:  result_o = a_i & b_i;
      default:  result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== muldiv_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module muldiv_unit
  import core_isa_pkg::*, core_pipe_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       start_i,
  input  muldiv_op_e op_i,
  input  xlen_t      a_i,
  input  xlen_t      b_i,
  output logic       busy_o,
  output logic       done_o,
  output xlen_t      result_o
);

  logic                     is_div;
  logic                     a_signed;
  logic                     b_signed;
  logic signed [XLEN:0]     mul_a;
  logic signed [XLEN:0]     mul_b;
  logic signed [2*XLEN+1:0] product;
  xlen_t                    mul_result;

  logic                     div_signed;
  xlen_t                    a_mag;
  xlen_t                    b_mag;
  logic                     div_run_q;
  logic                     div_done_q;
  logic [DIV_CNT_BITS-1:0]  step_q;
  xlen_t                    divisor_q;
  xlen_t                    quo_q;
  xlen_t                    rem_q;
  logic                     neg_quo_q;
  logic                     neg_rem_q;
  logic                     want_rem_q;
  logic [XLEN:0]            partial;
  xlen_t                    quo_out;
  xlen_t                    rem_out;

  assign is_div = op_i inside {md_div, md_divu, md_rem, md_remu};

  ////////////////////
  // multiply, single cycle
  ////////////////////

  assign a_signed   = op_i inside {md_mulh, md_mulhsu};
  assign b_signed   = (op_i == md_mulh);
  assign mul_a      = {a_signed & a_i[XLEN-1], a_i};
  assign mul_b      = {b_signed & b_i[XLEN-1], b_i};
  assign product    = mul_a * mul_b;
  assign mul_result = (op_i == md_mul) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];

  ////////////////////
  // restoring divide on magnitudes
  ////////////////////

  assign div_signed = op_i inside {md_div, md_rem};
  assign a_mag      = (div_signed && a_i[XLEN-1]) ? -a_i : a_i;
  assign b_mag      = (div_signed && b_i[XLEN-1]) ? -b_i : b_i;
  assign partial    = {rem_q, quo_q[XLEN-1]};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      div_run_q  <= 1'b0;
      div_done_q <= 1'b0;
      step_q     <= '0;
    end else begin
      div_done_q <= 1'b0;
      if (start_i && is_div) begin
        div_run_q <= 1'b1;
        step_q    <= '0;
      end else if (div_run_q) begin
        step_q <= step_q + 1'b1;
        if (step_q == DIV_CNT_BITS'(DIV_STEPS - 1)) begin
          div_run_q  <= 1'b0;
          div_done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && is_div) begin
      divisor_q  <= b_mag;
      quo_q      <= a_mag;
      rem_q      <= '0;
      // divide by zero keeps the all-ones magnitude unsigned
      neg_quo_q  <= div_signed & (a_i[XLEN-1] ^ b_i[XLEN-1]) & (b_i != '0);
      neg_rem_q  <= div_signed & a_i[XLEN-1];
      want_rem_q <= op_i inside {md_rem, md_remu};
    end else if (div_run_q) begin
      if (partial >= {1'b0, divisor_q}) begin
        rem_q <= partial[XLEN-1:0] - divisor_q;
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end else begin
        rem_q <= partial[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end
    end
  end

  // min / -1 lands on min with zero remainder without a special case
  assign quo_out = neg_quo_q ? -quo_q : quo_q;
  assign rem_out = neg_rem_q ? -rem_q : rem_q;

  assign busy_o   = div_run_q | div_done_q;
  assign done_o   = div_done_q | (start_i & ~is_div);
  assign result_o = div_done_q ? (want_rem_q ? rem_out : quo_out) : mul_result;

  a_no_start_when_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    start_i |-> !busy_o);

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module execute_stage
  import core_isa_pkg::*, core_pipe_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,

  input  logic       of_valid_i,
  input  exec_op_u   of_op_i,
  input  exec_path_e of_path_i,
  input  reg_addr_t  of_rd_i,
  input  reg_addr_t  of_rs1_addr_i,
  input  reg_addr_t  of_rs2_addr_i,
  input  xlen_t      of_rs1_i,
  input  xlen_t      of_rs2_i,
  input  logic       of_imm_valid_i,
  input  xlen_t      of_imm_i,

  input  logic       wb_valid_i,
  input  reg_addr_t  wb_rd_addr_i,
  input  xlen_t      wb_data_i,

  output logic       ex_accept_o,
  output logic       ex_valid_o,
  output reg_addr_t  ex_rd_o,
  output xlen_t      ex_result_o
);

  xlen_t     rs1_val;
  xlen_t     rs2_val;
  xlen_t     alu_b;
  xlen_t     alu_result;
  xlen_t     md_result;
  logic      md_start;
  logic      md_busy;
  logic      md_done;
  reg_addr_t md_rd_q;

  // newest copy wins: execute result, then writeback, then the fetched value
  function automatic xlen_t fwd_operand(input reg_addr_t src, input xlen_t fetched,
                                        input reg_addr_t ex_rd, input xlen_t ex_val,
                                        input reg_addr_t wb_rd, input xlen_t wb_val);
    if (src == '0) return fetched;
    if (src == ex_rd) return ex_val;
    if (src == wb_rd) return wb_val;
    return fetched;
  endfunction

  assign rs1_val = fwd_operand(of_rs1_addr_i, of_rs1_i, ex_rd_o, ex_result_o,
                               wb_rd_addr_i, wb_data_i);
  assign rs2_val = fwd_operand(of_rs2_addr_i, of_rs2_i, ex_rd_o, ex_result_o,
                               wb_rd_addr_i, wb_data_i);
  assign alu_b   = of_imm_valid_i ? of_imm_i : rs2_val;

  // a running divide blocks the stage
  assign ex_accept_o = of_valid_i & ~md_busy;
  assign md_start    = ex_accept_o & (of_path_i == path_muldiv);

  alu u_alu (
    .op_i     (of_op_i.alu),
    .a_i      (rs1_val),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  muldiv_unit u_muldiv (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .start_i  (md_start),
    .op_i     (of_op_i.md.op),
    .a_i      (rs1_val),
    .b_i      (rs2_val),
    .busy_o   (md_busy),
    .done_o   (md_done),
    .result_o (md_result)
  );

  // rd of the instruction in the multiply/divide unit
  always_ff @(posedge clk_i) begin
    if (md_start) begin
      md_rd_q <= of_rd_i;
    end
  end

  ////////////////////
  // stage result
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_valid_o <= 1'b0;
      ex_rd_o    <= '0;
    end else begin
      ex_valid_o <= 1'b0;
      if (ex_accept_o && of_path_i == path_alu) begin
        ex_valid_o  <= 1'b1;
        ex_rd_o     <= of_rd_i;
        ex_result_o <= alu_result;
      end else if (md_done) begin
        // multiply finishes on its start edge, divide later
        ex_valid_o  <= 1'b1;
        ex_rd_o     <= md_start ? of_rd_i : md_rd_q;
        ex_result_o <= md_result;
      end
    end
  end

  // forwarding assumes writeback takes every result on the next edge
  a_wb_follows_ex: assert property (@(posedge clk_i) disable iff (reset_i)
    ex_valid_o |=> (wb_valid_i && wb_rd_addr_i == $past(ex_rd_o) &&
                    wb_data_i == $past(ex_result_o)));

endmodule

`default_nettype wire

// ==== writeback_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module writeback_stage
  import core_isa_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  input  logic      ex_valid_i,
  input  reg_addr_t ex_rd_i,
  input  xlen_t     ex_result_i,

  input  reg_addr_t rf_rs1_addr_i,
  input  reg_addr_t rf_rs2_addr_i,
  output xlen_t     rf_rs1_o,
  output xlen_t     rf_rs2_o,

  output logic      wb_valid_o,
  output reg_addr_t wb_rd_addr_o,
  output xlen_t     wb_data_o
);

  xlen_t regs [2**REG_BITS];
  logic  rf_write;

  // rd and data hold the last retirement between pulses
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_valid_o   <= 1'b0;
      wb_rd_addr_o <= '0;
    end else begin
      wb_valid_o <= ex_valid_i;
      if (ex_valid_i) begin
        wb_rd_addr_o <= ex_rd_i;
        wb_data_o    <= ex_result_i;
      end
    end
  end

  ////////////////////
  // register file
  ////////////////////

  assign rf_write = wb_valid_o & (wb_rd_addr_o != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 2**REG_BITS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_write) begin
      regs[wb_rd_addr_o] <= wb_data_o;
    end
  end

  // write-through so a same-edge capture sees the new value
  assign rf_rs1_o = (rf_write && wb_rd_addr_o == rf_rs1_addr_i) ? wb_data_o : regs[rf_rs1_addr_i];
  assign rf_rs2_o = (rf_write && wb_rd_addr_o == rf_rs2_addr_i) ? wb_data_o : regs[rf_rs2_addr_i];

  a_x0_reads_zero: assert property (@(posedge clk_i) disable iff (reset_i)
    (rf_rs1_addr_i != '0 || rf_rs1_o == '0) && (rf_rs2_addr_i != '0 || rf_rs2_o == '0));

endmodule

`default_nettype wire

// ==== exec_pipe_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module exec_pipe_top
  import core_isa_pkg::*, core_pipe_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,

  input  logic       issue_valid_i,
  input  exec_op_u   op_i,
  input  exec_path_e path_i,
  input  reg_addr_t  rd_addr_i,
  input  reg_addr_t  rs1_addr_i,
  input  reg_addr_t  rs2_addr_i,
  input  logic       imm_valid_i,
  input  xlen_t      imm_i,
  output logic       issue_ready_o,

  output logic       wb_valid_o,
  output reg_addr_t  wb_rd_addr_o,
  output xlen_t      wb_data_o
);

  // opfetch to execute
  logic       of_valid;
  exec_op_u   of_op;
  exec_path_e of_path;
  reg_addr_t  of_rd;
  reg_addr_t  of_rs1_addr;
  reg_addr_t  of_rs2_addr;
  xlen_t      of_rs1;
  xlen_t      of_rs2;
  logic       of_imm_valid;
  xlen_t      of_imm;
  logic       ex_accept;

  // execute to writeback, register file reads
  logic       ex_valid;
  reg_addr_t  ex_rd;
  xlen_t      ex_result;
  reg_addr_t  rf_rs1_addr;
  reg_addr_t  rf_rs2_addr;
  xlen_t      rf_rs1;
  xlen_t      rf_rs2;

  opfetch_stage u_opfetch (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .issue_valid_i  (issue_valid_i),
    .op_i           (op_i),
    .path_i         (path_i),
    .rd_addr_i      (rd_addr_i),
    .rs1_addr_i     (rs1_addr_i),
    .rs2_addr_i     (rs2_addr_i),
    .imm_valid_i    (imm_valid_i),
    .imm_i          (imm_i),
    .issue_ready_o  (issue_ready_o),
    .rf_rs1_addr_o  (rf_rs1_addr),
    .rf_rs2_addr_o  (rf_rs2_addr),
    .rf_rs1_i       (rf_rs1),
    .rf_rs2_i       (rf_rs2),
    .ex_accept_i    (ex_accept),
    .of_valid_o     (of_valid),
    .of_op_o        (of_op),
    .of_path_o      (of_path),
    .of_rd_o        (of_rd),
    .of_rs1_addr_o  (of_rs1_addr),
    .of_rs2_addr_o  (of_rs2_addr),
    .of_rs1_o       (of_rs1),
    .of_rs2_o       (of_rs2),
    .of_imm_valid_o (of_imm_valid),
    .of_imm_o       (of_imm)
  );

  execute_stage u_execute (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .of_valid_i     (of_valid),
    .of_op_i        (of_op),
    .of_path_i      (of_path),
    .of_rd_i        (of_rd),
    .of_rs1_addr_i  (of_rs1_addr),
    .of_rs2_addr_i  (of_rs2_addr),
    .of_rs1_i       (of_rs1),
    .of_rs2_i       (of_rs2),
    .of_imm_valid_i (of_imm_valid),
    .of_imm_i       (of_imm),
    .wb_valid_i     (wb_valid_o),
    .wb_rd_addr_i   (wb_rd_addr_o),
    .wb_data_i      (wb_data_o),
    .ex_accept_o    (ex_accept),
    .ex_valid_o     (ex_valid),
    .ex_rd_o        (ex_rd),
    .ex_result_o    (ex_result)
  );

  writeback_stage u_writeback (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .ex_valid_i     (ex_valid),
    .ex_rd_i        (ex_rd),
    .ex_result_i    (ex_result),
    .rf_rs1_addr_i  (rf_rs1_addr),
    .rf_rs2_addr_i  (rf_rs2_addr),
    .rf_rs1_o       (rf_rs1),
    .rf_rs2_o       (rf_rs2),
    .wb_valid_o     (wb_valid_o),
    .wb_rd_addr_o   (wb_rd_addr_o),
    .wb_data_o      (wb_data_o)
  );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // reset held over the first two rising edges
  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    #1 reset_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb_exec_pipe.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_exec_pipe
  import core_isa_pkg::*, core_pipe_pkg::*;
();

  localparam int MAX_LINES = 128;
  localparam int MAX_TESTS = 16;

  logic       clk;
  logic       reset;
  logic       issue_valid;
  exec_op_u   op;
  exec_path_e path;
  reg_addr_t  rd_addr;
  reg_addr_t  rs1_addr;
  reg_addr_t  rs2_addr;
  logic       imm_valid;
  xlen_t      imm;
  logic       issue_ready;
  logic       wb_valid;
  reg_addr_t  wb_rd_addr;
  xlen_t      wb_data;

  // trace contents
  int         tr_test [MAX_LINES];
  exec_path_e tr_path [MAX_LINES];
  exec_op_u   tr_op [MAX_LINES];
  reg_addr_t  tr_rd [MAX_LINES];
  reg_addr_t  tr_rs1 [MAX_LINES];
  reg_addr_t  tr_rs2 [MAX_LINES];
  logic       tr_imm_valid [MAX_LINES];
  xlen_t      tr_imm [MAX_LINES];
  int         n_lines;

  // expected retirements in issue order
  int         exp_test_q [$];
  reg_addr_t  exp_rd_q [$];
  xlen_t      exp_data_q [$];

  int         left_in_test [MAX_TESTS];
  logic       test_bad [MAX_TESTS];
  int         errors;
  int         tests_passed;
  int         tests_failed;
  int         retired;
  int         stall_cycles;
  logic       saw_divide;
  int         seed;
  int         cycle_count;
  int         cycle_limit;
  logic       loaded = 1'b0;

  tb_clock_gen u_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  exec_pipe_top DUT (
    .clk_i         (clk),
    .reset_i       (reset),
    .issue_valid_i (issue_valid),
    .op_i          (op),
    .path_i        (path),
    .rd_addr_i     (rd_addr),
    .rs1_addr_i    (rs1_addr),
    .rs2_addr_i    (rs2_addr),
    .imm_valid_i   (imm_valid),
    .imm_i         (imm),
    .issue_ready_o (issue_ready),
    .wb_valid_o    (wb_valid),
    .wb_rd_addr_o  (wb_rd_addr),
    .wb_data_o     (wb_data)
  );

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_data(input int test, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("error at %0t: test %0d wb_data_o is %h, expected %h", $time, test, got, exp);
      errors++;
      test_bad[test] = 1'b1;
    end
  endtask

  task automatic check_reg(input int test, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("error at %0t: test %0d wb_rd_addr_o is x%0d, expected x%0d",
               $time, test, got, exp);
      errors++;
      test_bad[test] = 1'b1;
    end
  endtask

  task automatic check_level(input int test, input string name, input logic got,
                             input logic exp);
    if (got !== exp) begin
      $display("error at %0t: test %0d %s is %b, expected %b", $time, test, name, got, exp);
      errors++;
      test_bad[test] = 1'b1;
    end
  endtask

  ////////////////////
  // trace loading
  ////////////////////

  task automatic load_trace();
    int    fd;
    int    n;
    int    t;
    int    p;
    int    o;
    int    rd;
    int    rs1;
    int    rs2;
    int    iv;
    int    erd;
    xlen_t im;
    xlen_t ed;
    string line;
    fd = $fopen("exec_trace.txt", "r");
    if (fd == 0) begin
      return;
    end
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%d %d %h %d %d %d %d %h %d %h",
                  t, p, o, rd, rs1, rs2, iv, im, erd, ed);
      // comment and blank lines fall out here
      if (n == 10 && t >= 0 && t < MAX_TESTS && n_lines < MAX_LINES) begin
        tr_test[n_lines]      = t;
        tr_path[n_lines]      = exec_path_e'(p[1:0]);
        tr_op[n_lines]        = o[3:0];
        tr_rd[n_lines]        = rd[REG_BITS-1:0];
        tr_rs1[n_lines]       = rs1[REG_BITS-1:0];
        tr_rs2[n_lines]       = rs2[REG_BITS-1:0];
        tr_imm_valid[n_lines] = iv[0];
        tr_imm[n_lines]       = im;
        if (tr_path[n_lines] == path_muldiv &&
            tr_op[n_lines].md.op inside {md_div, md_divu, md_rem, md_remu}) begin
          saw_divide = 1'b1;
        end
        exp_test_q.push_back(t);
        exp_rd_q.push_back(erd[REG_BITS-1:0]);
        exp_data_q.push_back(ed);
        left_in_test[t]++;
        n_lines++;
      end
    end
    $fclose(fd);
  endtask

  ////////////////////
  // issue driver
  ////////////////////

  task automatic drive_line(input int i);
    issue_valid = 1'b1;
    op          = tr_op[i];
    path        = tr_path[i];
    rd_addr     = tr_rd[i];
    rs1_addr    = tr_rs1[i];
    rs2_addr    = tr_rs2[i];
    imm_valid   = tr_imm_valid[i];
    imm         = tr_imm[i];
  endtask

  // ready sampled mid-cycle, the edge after it takes the instruction
  task automatic wait_accept();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = issue_ready;
      if (!taken) begin
        stall_cycles++;
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic issue_all();
    int gap;
    for (int i = 0; i < n_lines; i++) begin
      drive_line(i);
      wait_accept();
      issue_valid = 1'b0;
      // instructions inside a test go back to back
      if (i + 1 < n_lines && tr_test[i + 1] != tr_test[i]) begin
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
    end
  endtask

  ////////////////////
  // retire checker
  ////////////////////

  task automatic retire_one();
    int t;
    if (exp_test_q.size() == 0) begin
      $display("at %0t wb_valid_o pulsed with no instruction outstanding", $time);
      errors++;
      return;
    end
    t = exp_test_q.pop_front();
    check_reg(t, wb_rd_addr, exp_rd_q.pop_front());
    check_data(t, wb_data, exp_data_q.pop_front());
    retired++;
    left_in_test[t]--;
    if (left_in_test[t] == 0) begin
      if (test_bad[t]) begin
        $display("test %0d failed", t);
        tests_failed++;
      end else begin
        $display("test %0d passed", t);
        tests_passed++;
      end
    end
  endtask

  always @(negedge clk) begin
    if (!reset && wb_valid) begin
      retire_one();
    end
  end

  // run limit scales with the trace length
  initial begin
    cycle_count = 0;
    wait (loaded);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the pipeline stopped retiring instructions",
             cycle_count);
    $display("Regression failed");
    $finish;
  end

  initial begin
    issue_valid  = 1'b0;
    op           = '0;
    path         = path_alu;
    rd_addr      = '0;
    rs1_addr     = '0;
    rs2_addr     = '0;
    imm_valid    = 1'b0;
    imm          = '0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    retired      = 0;
    stall_cycles = 0;
    saw_divide   = 1'b0;
    n_lines      = 0;
    seed         = 37674;
    for (int t = 0; t < MAX_TESTS; t++) begin
      left_in_test[t] = 0;
      test_bad[t]     = 1'b0;
    end
    load_trace();
    cycle_limit = n_lines * (DIV_STEPS + 6) + 50;
    loaded      = 1'b1;
    if (n_lines == 0) begin
      $display("no instructions could be read from exec_trace.txt");
      errors++;
    end
    @(negedge reset);
    @(negedge clk);
    check_level(1, "wb_valid_o", wb_valid, 1'b0);
    check_level(1, "issue_ready_o", issue_ready, 1'b1);
    @(posedge clk);
    #1;
    issue_all();
    wait (retired == n_lines);
    // a few idle cycles to catch stray retirements
    repeat (4) @(posedge clk);
    if (saw_divide && stall_cycles == 0) begin
      $display("issue_ready_o never dropped while a divide was running");
      errors++;
    end
    $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== exec_trace.txt ====
# test path op rd rs1 rs2 imm_valid imm exp_rd exp_data
# path 0 alu, 1 muldiv; op, imm and exp_data in hex, the rest decimal
1 0 0 1 0 0 0 00000000 1 00000000
2 0 0 1 0 0 1 12345678 1 12345678
2 0 0 2 0 0 1 fffffff0 2 fffffff0
2 0 0 3 1 2 0 00000000 3 12345668
2 0 8 4 1 2 0 00000000 4 12345688
2 0 1 5 1 0 1 00000004 5 23456780
2 0 2 6 2 1 0 00000000 6 00000001
2 0 3 7 2 1 0 00000000 7 00000000
2 0 4 8 1 0 1 ffff0000 8 edcb5678
2 0 5 9 2 0 1 00000004 9 0fffffff
2 0 d 10 2 0 1 00000024 10 ffffffff
2 0 6 11 1 2 0 00000000 11 fffffff8
2 0 7 12 1 0 1 0000ff0f 12 00005608
2 0 2 13 1 0 1 80000000 13 00000000
2 0 3 14 1 0 1 80000000 14 00000001
2 0 5 15 1 6 0 00000000 15 091a2b3c
3 0 0 16 0 0 1 00000005 16 00000005
3 0 0 17 16 16 0 00000000 17 0000000a
3 0 0 18 17 16 0 00000000 18 0000000f
3 0 8 19 18 16 0 00000000 19 0000000a
3 0 0 16 19 17 0 00000000 16 00000014
3 0 0 20 16 18 0 00000000 20 00000023
3 0 4 20 20 16 0 00000000 20 00000037
4 0 0 21 0 0 1 fffffffe 21 fffffffe
4 0 0 22 0 0 1 00000003 22 00000003
4 0 0 23 0 0 1 80000000 23 80000000
4 1 0 24 21 22 0 00000000 24 fffffffa
4 1 1 25 21 22 0 00000000 25 ffffffff
4 1 2 26 21 21 0 00000000 26 fffffffe
4 1 3 27 21 21 0 00000000 27 fffffffc
4 1 1 28 23 23 0 00000000 28 40000000
4 1 2 29 22 21 0 00000000 29 00000002
4 1 0 30 23 22 0 00000000 30 80000000
5 0 0 2 0 0 1 ffffffff 2 ffffffff
5 0 0 3 0 0 1 fffffff9 3 fffffff9
5 1 4 4 3 22 0 00000000 4 fffffffe
5 1 6 5 3 22 0 00000000 5 ffffffff
5 1 5 6 3 22 0 00000000 6 55555553
5 1 7 7 3 1 0 00000000 7 01234569
5 1 4 8 1 0 0 00000000 8 ffffffff
5 1 6 9 3 0 0 00000000 9 fffffff9
5 1 5 10 1 0 0 00000000 10 ffffffff
5 1 4 11 23 2 0 00000000 11 80000000
5 1 6 12 23 2 0 00000000 12 00000000
5 0 0 13 12 11 0 00000000 13 80000000
5 0 8 15 5 4 0 00000000 15 00000001
6 0 0 0 0 0 1 00000055 0 00000055
6 0 0 31 0 0 0 00000000 31 00000000
6 1 0 0 22 22 0 00000000 0 00000009
6 0 0 29 0 22 0 00000000 29 00000003

// ==== flist.f ====
core_isa_pkg.sv
core_pipe_pkg.sv
opfetch_stage.sv
alu.sv
muldiv_unit.sv
execute_stage.sv
writeback_stage.sv
exec_pipe_top.sv
tb_clock_gen.sv
tb_exec_pipe.sv

// ==== Bender.yml ====
package:
  name: exec_pipe

sources:
  - core_isa_pkg.sv
  - core_pipe_pkg.sv
  - opfetch_stage.sv
  - alu.sv
  - muldiv_unit.sv
  - execute_stage.sv
  - writeback_stage.sv
  - exec_pipe_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_exec_pipe.sv
